// ==== logic/lsuPkg.sv ====
package lsuPkg;

    localparam int LB_ENTRIES = 16;
    localparam int LB_IDX_W = 4;
    localparam int SQN_W = 7;
    localparam int LDSQN_W = 7;
    localparam int TAG_W = 6;
    localparam int ADDR_W = 32;

    // Upper load sequence bits kept per entry, the low bits are the entry index
    localparam int HIGH_W = LDSQN_W - LB_IDX_W;

    // Everything with bit 31 set is uncached device space
    localparam logic [ADDR_W-1:0] MMIO_BASE = 32'h8000_0000;

    // Size encoding is 0 byte, 1 half, 2 word
    function automatic logic [3:0] byteMask(
        input logic [1:0] lowAddr,
        input logic [1:0] size
    );
        logic [3:0] mask;
        case (size)
            2'd0: begin
                mask = 4'b0001 << lowAddr;
            end
            2'd1: begin
                mask = 4'b0011 << {lowAddr[1], 1'b0};
            end
            default: begin
                mask = 4'b1111;
            end
        endcase
        return mask;
    endfunction

    // True when a is strictly older than b, valid while both lie within half the number space
    function automatic logic sqnOlder(
        input logic [SQN_W-1:0] a,
        input logic [SQN_W-1:0] b
    );
        logic [SQN_W-1:0] diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

endpackage

// ==== logic/aguIntake.sv ====
module aguIntake
    import lsuPkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               aguValid,
    input  logic               aguIsLoad,
    input  logic               aguIsStore,
    input  logic [ADDR_W-1:0]  aguAddr,
    input  logic [1:0]         aguSize,
    input  logic               aguSignExtend,
    input  logic [TAG_W-1:0]   aguTag,
    input  logic [SQN_W-1:0]   aguSqN,
    input  logic [LDSQN_W-1:0] aguLoadSqN,
    input  logic [ADDR_W-1:0]  aguPc,
    input  logic               aguCompressed,

    output logic               opValid,
    output logic               opIsLoad,
    output logic               opIsStore,
    output logic [ADDR_W-1:0]  opAddr,
    output logic [1:0]         opSize,
    output logic [3:0]         opMask,
    output logic               opSignExtend,
    output logic [TAG_W-1:0]   opTag,
    output logic [SQN_W-1:0]   opSqN,
    output logic [LDSQN_W-1:0] opLoadSqN,
    output logic [ADDR_W-1:0]  opPc,
    output logic               opCompressed,
    output logic               opMmio
);

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid <= 1'b0;
        end else begin
            opValid <= aguValid;
        end
    end

    // Mask and region are decoded here once so the buffer and the port logic
    // both see them straight from a register
    always_ff @(posedge clk) begin
        if (aguValid) begin
            opIsLoad <= aguIsLoad;
            opIsStore <= aguIsStore;
            opAddr <= aguAddr;
            opSize <= aguSize;
            opMask <= byteMask(aguAddr[1:0], aguSize);
            opSignExtend <= aguSignExtend;
            opTag <= aguTag;
            opSqN <= aguSqN;
            opLoadSqN <= aguLoadSqN;
            opPc <= aguPc;
            opCompressed <= aguCompressed;
            opMmio <= (aguAddr >= MMIO_BASE);
        end
    end

endmodule

// ==== logic/loadBuffer.sv ====
module loadBuffer
    import lsuPkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               opValid,
    input  logic               opIsLoad,
    input  logic               opIsStore,
    input  logic [ADDR_W-1:0]  opAddr,
    input  logic [1:0]         opSize,
    input  logic [3:0]         opMask,
    input  logic               opSignExtend,
    input  logic [TAG_W-1:0]   opTag,
    input  logic [SQN_W-1:0]   opSqN,
    input  logic [LDSQN_W-1:0] opLoadSqN,
    input  logic [ADDR_W-1:0]  opPc,
    input  logic               opCompressed,
    input  logic               opMmio,

    input  logic [LDSQN_W-1:0] comLoadSqN,
    input  logic [SQN_W-1:0]   comSqN,
    input  logic               sqDone,

    input  logic               ackValid,
    input  logic               ackFail,
    input  logic [LDSQN_W-1:0] ackLoadSqN,

    input  logic               flushValid,
    input  logic [LDSQN_W-1:0] flushLoadSqN,

    input  logic               lateTaken,
    output logic               lateValid,
    output logic [ADDR_W-1:0]  lateAddr,
    output logic [1:0]         lateSize,
    output logic               lateSignExtend,
    output logic [TAG_W-1:0]   lateTag,
    output logic [SQN_W-1:0]   lateSqN,
    output logic [LDSQN_W-1:0] lateLoadSqN,
    output logic               lateMmio,

    output logic               redirValid,
    output logic [ADDR_W-1:0]  redirPc,
    output logic [SQN_W-1:0]   redirSqN,
    output logic [LDSQN_W-1:0] redirLoadSqN,

    output logic [LDSQN_W-1:0] maxLoadSqN
);

    logic [ADDR_W-1:0]  entAddr [LB_ENTRIES];
    logic [1:0]         entSize [LB_ENTRIES];
    logic [3:0]         entMask [LB_ENTRIES];
    logic               entSignExtend [LB_ENTRIES];
    logic [TAG_W-1:0]   entTag [LB_ENTRIES];
    logic [SQN_W-1:0]   entSqN [LB_ENTRIES];
    logic [HIGH_W-1:0]  entHigh [LB_ENTRIES];
    logic [LDSQN_W-1:0] entLdSqN [LB_ENTRIES];
    logic [LB_ENTRIES-1:0] entMmio;
    logic [LB_ENTRIES-1:0] entIssued;
    logic [LB_ENTRIES-1:0] entValid;

    logic [LDSQN_W-1:0]  lastComLoadSqN;
    logic [LB_IDX_W-1:0] deqIndex;
    logic [LB_IDX_W-1:0] selIdx;
    logic [LB_IDX_W-1:0] insIdx;
    logic [LB_IDX_W-1:0] ackIdx;
    logic                mmioReady;
    logic                insertOk;
    logic                ackHit;
    logic                storeHit;
    logic [LB_ENTRIES-1:0] conflict;
    logic [LB_ENTRIES-1:0] killMask;

    assign deqIndex = comLoadSqN[LB_IDX_W-1:0];
    assign insIdx = opLoadSqN[LB_IDX_W-1:0];
    assign ackIdx = ackLoadSqN[LB_IDX_W-1:0];

    always_comb begin
        for (int i = 0; i < LB_ENTRIES; i++) begin
            entLdSqN[i] = {entHigh[i], LB_IDX_W'(i)};
        end
    end

    // Device loads leave strictly in program order with no older store pending
    assign mmioReady = entValid[deqIndex] && !entIssued[deqIndex] && entMmio[deqIndex] &&
                       entLdSqN[deqIndex] == comLoadSqN && entSqN[deqIndex] == comSqN &&
                       sqDone;

    always_comb begin
        logic [LB_IDX_W-1:0] idx;
        lateValid = 1'b0;
        selIdx = deqIndex;
        for (int i = 0; i < LB_ENTRIES; i++) begin
            idx = deqIndex + LB_IDX_W'(i);
            if (!lateValid && entValid[idx] && !entIssued[idx] && !entMmio[idx]) begin
                lateValid = 1'b1;
                selIdx = idx;
            end
        end
        if (mmioReady) begin
            lateValid = 1'b1;
            selIdx = deqIndex;
        end
    end

    assign lateAddr = entAddr[selIdx];
    assign lateSize = entSize[selIdx];
    assign lateSignExtend = entSignExtend[selIdx];
    assign lateTag = entTag[selIdx];
    assign lateSqN = entSqN[selIdx];
    assign lateLoadSqN = entLdSqN[selIdx];
    assign lateMmio = entMmio[selIdx];

    // A store hit means a younger load already read stale data
    always_comb begin
        for (int i = 0; i < LB_ENTRIES; i++) begin
            conflict[i] = entValid[i] && entIssued[i] &&
                          !(flushValid && !sqnOlder(entLdSqN[i], flushLoadSqN)) &&
                          !sqnOlder(entLdSqN[i], opLoadSqN) &&
                          entAddr[i][ADDR_W-1:2] == opAddr[ADDR_W-1:2] &&
                          |(entMask[i] & opMask);
        end
    end

    assign storeHit = opValid && opIsStore && |conflict;

    always_comb begin
        for (int i = 0; i < LB_ENTRIES; i++) begin
            killMask[i] = entValid[i] &&
                          (sqnOlder(entLdSqN[i], lastComLoadSqN) ||
                           (flushValid && !sqnOlder(entLdSqN[i], flushLoadSqN)) ||
                           (storeHit && !sqnOlder(entLdSqN[i], opLoadSqN)));
        end
    end

    assign insertOk = opValid && opIsLoad &&
                      !(flushValid && !sqnOlder(opLoadSqN, flushLoadSqN));

    assign ackHit = ackValid && ackFail && entValid[ackIdx] &&
                    entHigh[ackIdx] == ackLoadSqN[LDSQN_W-1:LB_IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            entIssued <= '0;
            redirValid <= 1'b0;
        end else begin
            redirValid <= storeHit;
            if (ackHit) begin
                entIssued[ackIdx] <= 1'b0;
            end
            if (lateTaken) begin
                entIssued[selIdx] <= 1'b1;
            end
            for (int i = 0; i < LB_ENTRIES; i++) begin
                if (killMask[i]) begin
                    entValid[i] <= 1'b0;
                end
            end
            // Regular loads go to memory straight away, device loads wait here
            if (insertOk) begin
                entValid[insIdx] <= 1'b1;
                entIssued[insIdx] <= !opMmio;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insertOk) begin
            entAddr[insIdx] <= opAddr;
            entSize[insIdx] <= opSize;
            entMask[insIdx] <= opMask;
            entSignExtend[insIdx] <= opSignExtend;
            entTag[insIdx] <= opTag;
            entSqN[insIdx] <= opSqN;
            entHigh[insIdx] <= opLoadSqN[LDSQN_W-1:LB_IDX_W];
            entMmio[insIdx] <= opMmio;
        end
    end

    // Fetch restarts after the store, so the store's own snapshot is enough
    always_ff @(posedge clk) begin
        if (storeHit) begin
            redirPc <= opPc + (opCompressed ? 32'd2 : 32'd4);
            redirSqN <= opSqN;
            redirLoadSqN <= opLoadSqN;
        end
    end

    always_ff @(posedge clk) begin
        lastComLoadSqN <= comLoadSqN;
        maxLoadSqN <= comLoadSqN + LDSQN_W'(LB_ENTRIES - 1);
    end

endmodule

// ==== logic/loadIssue.sv ====
module loadIssue
    import lsuPkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               opValid,
    input  logic               opIsLoad,
    input  logic               opMmio,
    input  logic [ADDR_W-1:0]  opAddr,
    input  logic [1:0]         opSize,
    input  logic               opSignExtend,
    input  logic [TAG_W-1:0]   opTag,
    input  logic [SQN_W-1:0]   opSqN,
    input  logic [LDSQN_W-1:0] opLoadSqN,

    input  logic               lateValid,
    input  logic [ADDR_W-1:0]  lateAddr,
    input  logic [1:0]         lateSize,
    input  logic               lateSignExtend,
    input  logic [TAG_W-1:0]   lateTag,
    input  logic [SQN_W-1:0]   lateSqN,
    input  logic [LDSQN_W-1:0] lateLoadSqN,
    input  logic               lateMmio,
    output logic               lateTaken,

    output logic               ldValid,
    output logic [ADDR_W-1:0]  ldAddr,
    output logic [1:0]         ldSize,
    output logic               ldSignExtend,
    output logic [TAG_W-1:0]   ldTag,
    output logic [SQN_W-1:0]   ldSqN,
    output logic [LDSQN_W-1:0] ldLoadSqN,
    output logic               ldMmio,

    input  logic               flushValid,
    input  logic [LDSQN_W-1:0] flushLoadSqN
);

    logic               immValid;
    logic [LDSQN_W-1:0] chosenLoadSqN;
    logic               dropped;

    // A fresh cacheable load always owns the port
    assign immValid = opValid && opIsLoad && !opMmio;
    assign lateTaken = lateValid && !immValid;

    assign chosenLoadSqN = immValid ? opLoadSqN : lateLoadSqN;
    assign dropped = flushValid && !sqnOlder(chosenLoadSqN, flushLoadSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            ldValid <= 1'b0;
        end else begin
            ldValid <= (immValid || lateValid) && !dropped;
        end
    end

    always_ff @(posedge clk) begin
        if (immValid) begin
            ldAddr <= opAddr;
            ldSize <= opSize;
            ldSignExtend <= opSignExtend;
            ldTag <= opTag;
            ldSqN <= opSqN;
            ldLoadSqN <= opLoadSqN;
            ldMmio <= opMmio;
        end else if (lateValid) begin
            ldAddr <= lateAddr;
            ldSize <= lateSize;
            ldSignExtend <= lateSignExtend;
            ldTag <= lateTag;
            ldSqN <= lateSqN;
            ldLoadSqN <= lateLoadSqN;
            ldMmio <= lateMmio;
        end
    end

endmodule

// ==== logic/loadQueueTop.sv ====
module loadQueueTop
    import lsuPkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               aguValid,
    input  logic               aguIsLoad,
    input  logic               aguIsStore,
    input  logic [ADDR_W-1:0]  aguAddr,
    input  logic [1:0]         aguSize,
    input  logic               aguSignExtend,
    input  logic [TAG_W-1:0]   aguTag,
    input  logic [SQN_W-1:0]   aguSqN,
    input  logic [LDSQN_W-1:0] aguLoadSqN,
    input  logic [ADDR_W-1:0]  aguPc,
    input  logic               aguCompressed,

    input  logic [LDSQN_W-1:0] comLoadSqN,
    input  logic [SQN_W-1:0]   comSqN,
    input  logic               sqDone,

    input  logic               ackValid,
    input  logic               ackFail,
    input  logic [LDSQN_W-1:0] ackLoadSqN,

    input  logic               flushValid,
    input  logic [LDSQN_W-1:0] flushLoadSqN,

    output logic               ldValid,
    output logic [ADDR_W-1:0]  ldAddr,
    output logic [1:0]         ldSize,
    output logic               ldSignExtend,
    output logic [TAG_W-1:0]   ldTag,
    output logic [SQN_W-1:0]   ldSqN,
    output logic [LDSQN_W-1:0] ldLoadSqN,
    output logic               ldMmio,

    output logic               redirValid,
    output logic [ADDR_W-1:0]  redirPc,
    output logic [SQN_W-1:0]   redirSqN,
    output logic [LDSQN_W-1:0] redirLoadSqN,

    output logic [LDSQN_W-1:0] maxLoadSqN
);

    logic               opValid;
    logic               opIsLoad;
    logic               opIsStore;
    logic [ADDR_W-1:0]  opAddr;
    logic [1:0]         opSize;
    logic [3:0]         opMask;
    logic               opSignExtend;
    logic [TAG_W-1:0]   opTag;
    logic [SQN_W-1:0]   opSqN;
    logic [LDSQN_W-1:0] opLoadSqN;
    logic [ADDR_W-1:0]  opPc;
    logic               opCompressed;
    logic               opMmio;

    logic               lateValid;
    logic [ADDR_W-1:0]  lateAddr;
    logic [1:0]         lateSize;
    logic               lateSignExtend;
    logic [TAG_W-1:0]   lateTag;
    logic [SQN_W-1:0]   lateSqN;
    logic [LDSQN_W-1:0] lateLoadSqN;
    logic               lateMmio;
    logic               lateTaken;

    aguIntake i_aguIntake (
        .clk           (clk),
        .rst           (rst),
        .aguValid      (aguValid),
        .aguIsLoad     (aguIsLoad),
        .aguIsStore    (aguIsStore),
        .aguAddr       (aguAddr),
        .aguSize       (aguSize),
        .aguSignExtend (aguSignExtend),
        .aguTag        (aguTag),
        .aguSqN        (aguSqN),
        .aguLoadSqN    (aguLoadSqN),
        .aguPc         (aguPc),
        .aguCompressed (aguCompressed),
        .opValid       (opValid),
        .opIsLoad      (opIsLoad),
        .opIsStore     (opIsStore),
        .opAddr        (opAddr),
        .opSize        (opSize),
        .opMask        (opMask),
        .opSignExtend  (opSignExtend),
        .opTag         (opTag),
        .opSqN         (opSqN),
        .opLoadSqN     (opLoadSqN),
        .opPc          (opPc),
        .opCompressed  (opCompressed),
        .opMmio        (opMmio)
    );

    loadBuffer i_loadBuffer (
        .clk            (clk),
        .rst            (rst),
        .opValid        (opValid),
        .opIsLoad       (opIsLoad),
        .opIsStore      (opIsStore),
        .opAddr         (opAddr),
        .opSize         (opSize),
        .opMask         (opMask),
        .opSignExtend   (opSignExtend),
        .opTag          (opTag),
        .opSqN          (opSqN),
        .opLoadSqN      (opLoadSqN),
        .opPc           (opPc),
        .opCompressed   (opCompressed),
        .opMmio         (opMmio),
        .comLoadSqN     (comLoadSqN),
        .comSqN         (comSqN),
        .sqDone         (sqDone),
        .ackValid       (ackValid),
        .ackFail        (ackFail),
        .ackLoadSqN     (ackLoadSqN),
        .flushValid     (flushValid),
        .flushLoadSqN   (flushLoadSqN),
        .lateTaken      (lateTaken),
        .lateValid      (lateValid),
        .lateAddr       (lateAddr),
        .lateSize       (lateSize),
        .lateSignExtend (lateSignExtend),
        .lateTag        (lateTag),
        .lateSqN        (lateSqN),
        .lateLoadSqN    (lateLoadSqN),
        .lateMmio       (lateMmio),
        .redirValid     (redirValid),
        .redirPc        (redirPc),
        .redirSqN       (redirSqN),
        .redirLoadSqN   (redirLoadSqN),
        .maxLoadSqN     (maxLoadSqN)
    );

    loadIssue i_loadIssue (
        .clk            (clk),
        .rst            (rst),
        .opValid        (opValid),
        .opIsLoad       (opIsLoad),
        .opMmio         (opMmio),
        .opAddr         (opAddr),
        .opSize         (opSize),
        .opSignExtend   (opSignExtend),
        .opTag          (opTag),
        .opSqN          (opSqN),
        .opLoadSqN      (opLoadSqN),
        .lateValid      (lateValid),
        .lateAddr       (lateAddr),
        .lateSize       (lateSize),
        .lateSignExtend (lateSignExtend),
        .lateTag        (lateTag),
        .lateSqN        (lateSqN),
        .lateLoadSqN    (lateLoadSqN),
        .lateMmio       (lateMmio),
        .lateTaken      (lateTaken),
        .ldValid        (ldValid),
        .ldAddr         (ldAddr),
        .ldSize         (ldSize),
        .ldSignExtend   (ldSignExtend),
        .ldTag          (ldTag),
        .ldSqN          (ldSqN),
        .ldLoadSqN      (ldLoadSqN),
        .ldMmio         (ldMmio),
        .flushValid     (flushValid),
        .flushLoadSqN   (flushLoadSqN)
    );

endmodule

// ==== dv/loadQueueTb.sv ====
module loadQueueTb
    import lsuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 250;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * CYCLES_PER_TEST;
    localparam int SEQ_SPACE = 2 ** LDSQN_W;
    localparam int REPLAY_LIMIT = 20;

    logic               clk;
    logic               rst;
    logic               aguValid;
    logic               aguIsLoad;
    logic               aguIsStore;
    logic [ADDR_W-1:0]  aguAddr;
    logic [1:0]         aguSize;
    logic               aguSignExtend;
    logic [TAG_W-1:0]   aguTag;
    logic [SQN_W-1:0]   aguSqN;
    logic [LDSQN_W-1:0] aguLoadSqN;
    logic [ADDR_W-1:0]  aguPc;
    logic               aguCompressed;
    logic [LDSQN_W-1:0] comLoadSqN;
    logic [SQN_W-1:0]   comSqN;
    logic               sqDone;
    logic               ackValid;
    logic               ackFail;
    logic [LDSQN_W-1:0] ackLoadSqN;
    logic               flushValid;
    logic [LDSQN_W-1:0] flushLoadSqN;
    logic               ldValid;
    logic [ADDR_W-1:0]  ldAddr;
    logic [1:0]         ldSize;
    logic               ldSignExtend;
    logic [TAG_W-1:0]   ldTag;
    logic [SQN_W-1:0]   ldSqN;
    logic [LDSQN_W-1:0] ldLoadSqN;
    logic               ldMmio;
    logic               redirValid;
    logic [ADDR_W-1:0]  redirPc;
    logic [SQN_W-1:0]   redirSqN;
    logic [LDSQN_W-1:0] redirLoadSqN;
    logic [LDSQN_W-1:0] maxLoadSqN;

    int cycle = 0;
    logic [15:0] lfsrState = 16'd44831;

    // Expected loads indexed by load sequence number
    // Tests raise wantCount and the monitor raises gotCount
    logic [ADDR_W-1:0] expAddr [SEQ_SPACE];
    logic [1:0]        expSize [SEQ_SPACE];
    logic              expSignExtend [SEQ_SPACE];
    logic [TAG_W-1:0]  expTag [SEQ_SPACE];
    logic [SQN_W-1:0]  expSqN [SEQ_SPACE];
    logic              expMmio [SEQ_SPACE];
    logic              holdFlag [SEQ_SPACE];
    logic              exactDue [SEQ_SPACE];
    int                dueCycle [SEQ_SPACE];
    int                wantCount [SEQ_SPACE];
    int                gotCount [SEQ_SPACE];

    int                 redirWant = 0;
    int                 redirGot = 0;
    int                 redirDue = 0;
    logic [ADDR_W-1:0]  expRedirPc;
    logic [SQN_W-1:0]   expRedirSqN;
    logic [LDSQN_W-1:0] expRedirLoadSqN;
    logic [LDSQN_W-1:0] comAtLastNeg;

    loadQueueTop i_loadQueueTop (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            reportProblem($sformatf("Timeout, the run did not finish within %0d cycles", cycle));
            $fatal(1);
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        $display("TEST FAILED");
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        $display("TEST FAILED");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            reportMismatch(name, expected, actual);
            $fatal(1);
        end
    endtask

    // Galois LFSR with taps 16, 14, 13, 11
    function automatic logic nextBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    function automatic logic anyPending();
        logic [LDSQN_W-1:0] idx;
        logic busy;
        busy = (redirWant > redirGot);
        for (int i = 0; i < SEQ_SPACE; i++) begin
            idx = LDSQN_W'(i);
            if (wantCount[idx] > gotCount[idx] && !holdFlag[idx]) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // Outputs are sampled half a cycle after the edge that registered them
    always @(negedge clk) begin
        logic [LDSQN_W-1:0] sq;
        logic [LDSQN_W-1:0] idx;
        if (rst) begin
            if (cycle > 0) begin
                checkValue("ldValid", 32'd0, 32'(ldValid));
                checkValue("redirValid", 32'd0, 32'(redirValid));
            end
        end else begin
            if (ldValid) begin
                sq = ldLoadSqN;
                assert (wantCount[sq] > gotCount[sq]) else begin
                    reportProblem($sformatf("ldValid for load %0d with no issue expected", sq));
                    $fatal(1);
                end
                assert (!holdFlag[sq]) else begin
                    reportProblem($sformatf("MMIO load %0d issued while it had to wait", sq));
                    $fatal(1);
                end
                if (exactDue[sq]) begin
                    checkValue("ldValid cycle", 32'(dueCycle[sq]), 32'(cycle));
                end
                checkValue("ldAddr", expAddr[sq], ldAddr);
                checkValue("ldSize", 32'(expSize[sq]), 32'(ldSize));
                checkValue("ldSignExtend", 32'(expSignExtend[sq]), 32'(ldSignExtend));
                checkValue("ldTag", 32'(expTag[sq]), 32'(ldTag));
                checkValue("ldSqN", 32'(expSqN[sq]), 32'(ldSqN));
                checkValue("ldMmio", 32'(expMmio[sq]), 32'(ldMmio));
                gotCount[sq] = gotCount[sq] + 1;
            end
            for (int i = 0; i < SEQ_SPACE; i++) begin
                idx = LDSQN_W'(i);
                assert (!(wantCount[idx] > gotCount[idx] && !holdFlag[idx] &&
                          cycle > dueCycle[idx])) else begin
                    reportProblem($sformatf("Load %0d did not issue by cycle %0d",
                                            idx, dueCycle[idx]));
                    $fatal(1);
                end
            end
            if (redirValid) begin
                assert (redirWant > redirGot) else begin
                    reportProblem("redirValid raised with no store conflict expected");
                    $fatal(1);
                end
                checkValue("redirValid cycle", 32'(redirDue), 32'(cycle));
                checkValue("redirPc", expRedirPc, redirPc);
                checkValue("redirSqN", 32'(expRedirSqN), 32'(redirSqN));
                checkValue("redirLoadSqN", 32'(expRedirLoadSqN), 32'(redirLoadSqN));
                redirGot = redirGot + 1;
            end
            assert (!(redirWant > redirGot && cycle > redirDue)) else begin
                reportProblem($sformatf("Expected redirect missing at cycle %0d", redirDue));
                $fatal(1);
            end
        end
        // The window top lags the commit pointer by one register stage
        if (cycle >= 2) begin
            checkValue("maxLoadSqN", 32'(LDSQN_W'(comAtLastNeg + 7'd15)), 32'(maxLoadSqN));
        end
        comAtLastNeg = comLoadSqN;
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) nextCycle();
    endtask

    task automatic waitDrain();
        while (anyPending()) begin
            nextCycle();
        end
    endtask

    task automatic setCommit(input int lsq, input int sq);
        comLoadSqN = LDSQN_W'(lsq);
        comSqN = SQN_W'(sq);
    endtask

    task automatic sendLoad(input int lsq, input int sq, input logic [31:0] addr,
                            input int size, input int signExt, input int tag);
        logic [LDSQN_W-1:0] idx;
        idx = LDSQN_W'(lsq);
        expAddr[idx] = addr;
        expSize[idx] = 2'(size);
        expSignExtend[idx] = 1'(signExt);
        expTag[idx] = TAG_W'(tag);
        expSqN[idx] = SQN_W'(sq);
        expMmio[idx] = (addr >= MMIO_BASE);
        holdFlag[idx] = (addr >= MMIO_BASE);
        exactDue[idx] = 1'b1;
        dueCycle[idx] = cycle + 2;
        wantCount[idx] = wantCount[idx] + 1;
        aguIsLoad = 1'b1;
        aguIsStore = 1'b0;
        aguAddr = addr;
        aguSize = 2'(size);
        aguSignExtend = 1'(signExt);
        aguTag = TAG_W'(tag);
        aguSqN = SQN_W'(sq);
        aguLoadSqN = idx;
        aguPc = 32'h0000_1000;
        aguCompressed = 1'b0;
        aguValid = 1'b1;
        nextCycle();
        aguValid = 1'b0;
    endtask

    task automatic sendRandomLoad(input int lsq, input int sq);
        logic [31:0] addr;
        logic [1:0] size;
        logic [31:0] signExt;
        logic [31:0] tag;
        addr = randBits(31);
        size = 2'(randBits(2));
        if (size == 2'd3) begin
            size = 2'd2;
        end
        signExt = randBits(1);
        tag = randBits(TAG_W);
        sendLoad(lsq, sq, addr, int'(size), int'(signExt), int'(tag));
    endtask

    task automatic sendStore(input int lsq, input int sq, input logic [31:0] addr,
                             input int size, input logic [31:0] pc, input int compressed,
                             input int expectHit);
        if (expectHit != 0) begin
            expRedirPc = pc + ((compressed != 0) ? 32'd2 : 32'd4);
            expRedirSqN = SQN_W'(sq);
            expRedirLoadSqN = LDSQN_W'(lsq);
            redirDue = cycle + 2;
            redirWant = redirWant + 1;
        end
        aguIsLoad = 1'b0;
        aguIsStore = 1'b1;
        aguAddr = addr;
        aguSize = 2'(size);
        aguSignExtend = 1'b0;
        aguTag = '0;
        aguSqN = SQN_W'(sq);
        aguLoadSqN = LDSQN_W'(lsq);
        aguPc = pc;
        aguCompressed = 1'(compressed);
        aguValid = 1'b1;
        nextCycle();
        aguValid = 1'b0;
    endtask

    task automatic sendAck(input int lsq, input int fail, input int expectReplay);
        logic [LDSQN_W-1:0] idx;
        idx = LDSQN_W'(lsq);
        if (expectReplay != 0) begin
            exactDue[idx] = 1'b0;
            dueCycle[idx] = cycle + REPLAY_LIMIT;
            wantCount[idx] = wantCount[idx] + 1;
        end
        ackLoadSqN = idx;
        ackFail = 1'(fail);
        ackValid = 1'b1;
        nextCycle();
        ackValid = 1'b0;
    endtask

    task automatic sendFlush(input int lsq);
        flushLoadSqN = LDSQN_W'(lsq);
        flushValid = 1'b1;
        nextCycle();
        flushValid = 1'b0;
    endtask

    task automatic releaseMmio(input int lsq);
        logic [LDSQN_W-1:0] idx;
        idx = LDSQN_W'(lsq);
        holdFlag[idx] = 1'b0;
        exactDue[idx] = 1'b0;
        dueCycle[idx] = cycle + 4;
    endtask

    task automatic randomLoads();
        setCommit(0, 0);
        for (int i = 0; i < 12; i++) begin
            sendRandomLoad(i, i);
        end
        waitDrain();
        // A good response must not bring a load back
        sendAck(2, 0, 0);
        sendAck(5, 0, 0);
        sendAck(9, 0, 0);
        idle(10);
        setCommit(16, 20);
        idle(3);
    endtask

    task automatic mmioOrdering();
        sqDone = 1'b0;
        sendLoad(16, 21, MMIO_BASE + 32'h40, 2, 0, 5);
        idle(6);
        comSqN = 7'd21;
        idle(6);
        sqDone = 1'b1;
        comSqN = 7'd20;
        idle(6);
        releaseMmio(16);
        comSqN = 7'd21;
        waitDrain();
        idle(4);
        // Second device load waits on the load commit pointer alone
        comSqN = 7'd22;
        sendLoad(17, 22, MMIO_BASE + 32'h80, 0, 1, 9);
        idle(6);
        releaseMmio(17);
        comLoadSqN = 7'd17;
        waitDrain();
        idle(4);
    endtask

    task automatic failedAckReplay();
        setCommit(32, 40);
        idle(2);
        sendRandomLoad(32, 41);
        sendRandomLoad(33, 42);
        sendRandomLoad(34, 43);
        waitDrain();
        sendAck(33, 1, 1);
        waitDrain();
        sendAck(34, 0, 0);
        idle(10);
        sendAck(32, 1, 1);
        sendAck(34, 1, 1);
        waitDrain();
        idle(4);
    endtask

    task automatic storeConflicts();
        setCommit(48, 60);
        idle(2);
        sendLoad(50, 62, 32'h0000_1202, 1, 1, 3);
        sendLoad(51, 63, 32'h0000_1300, 2, 0, 4);
        sendLoad(52, 64, 32'h0000_1400, 0, 0, 6);
        waitDrain();
        sendStore(49, 61, 32'h0000_1204, 2, 32'h0000_0300, 0, 0);
        idle(4);
        sendStore(49, 61, 32'h0000_1200, 1, 32'h0000_0300, 0, 0);
        idle(4);
        sendStore(49, 61, 32'h0000_1403, 0, 32'h0000_0300, 0, 0);
        idle(4);
        sendStore(51, 61, 32'h0000_1301, 0, 32'h0000_0400, 1, 1);
        waitDrain();
        // Loads 51 and 52 went away with the redirect
        sendAck(51, 1, 0);
        sendAck(52, 1, 0);
        idle(12);
        sendAck(50, 1, 1);
        waitDrain();
        sendStore(49, 60, 32'h0000_1203, 0, 32'h0000_0800, 0, 1);
        waitDrain();
        sendAck(50, 1, 0);
        idle(12);
    endtask

    task automatic flushedLoads();
        setCommit(64, 70);
        idle(2);
        sendLoad(65, 72, 32'h0000_2000, 2, 0, 11);
        sendLoad(66, 73, 32'h0000_2100, 2, 1, 12);
        sendLoad(67, 74, 32'h0000_2200, 2, 0, 13);
        waitDrain();
        sendFlush(66);
        sendAck(66, 1, 0);
        sendAck(67, 1, 0);
        idle(12);
        sendStore(64, 71, 32'h0000_2100, 2, 32'h0000_0C00, 0, 0);
        idle(6);
        sendAck(65, 1, 1);
        waitDrain();
        sendStore(64, 75, 32'h0000_2000, 1, 32'h0000_0C00, 0, 1);
        waitDrain();
        idle(4);
    endtask

    task automatic commitWindow();
        setCommit(80, 90);
        idle(2);
        sendRandomLoad(81, 91);
        waitDrain();
        setCommit(86, 95);
        idle(3);
        // Entry 81 is behind the commit pointer now
        sendAck(81, 1, 0);
        idle(10);
        for (int k = 1; k <= 8; k++) begin
            setCommit(86 + 9 * k, 95 + k);
            idle(2);
        end
        idle(4);
    endtask

    initial begin
        rst = 1'b1;
        aguValid = 1'b0;
        aguIsLoad = 1'b0;
        aguIsStore = 1'b0;
        aguAddr = '0;
        aguSize = '0;
        aguSignExtend = 1'b0;
        aguTag = '0;
        aguSqN = '0;
        aguLoadSqN = '0;
        aguPc = '0;
        aguCompressed = 1'b0;
        comLoadSqN = '0;
        comSqN = '0;
        sqDone = 1'b1;
        ackValid = 1'b0;
        ackFail = 1'b0;
        ackLoadSqN = '0;
        flushValid = 1'b0;
        flushLoadSqN = '0;
        for (int i = 0; i < SEQ_SPACE; i++) begin
            holdFlag[LDSQN_W'(i)] = 1'b0;
            exactDue[LDSQN_W'(i)] = 1'b0;
            dueCycle[LDSQN_W'(i)] = 0;
            wantCount[LDSQN_W'(i)] = 0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        randomLoads();
        mmioOrdering();
        failedAckReplay();
        storeConflicts();
        flushedLoads();
        commitWindow();
        waitDrain();
        idle(4);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== loadQueueTop.f ====
logic/lsuPkg.sv
logic/aguIntake.sv
logic/loadBuffer.sv
logic/loadIssue.sv
logic/loadQueueTop.sv
dv/loadQueueTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= loadQueueTb
FILELIST  ?= loadQueueTop.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
